/* ex_stage_pkg.sv */
// Execute stage shared types
package ex_stage_pkg;

  // Data path and register file widths
  localparam int WORD_W    = 32;
  localparam int REGADDR_W = 6;
  localparam int ALU_OP_W  = 4;
  localparam int MULT_OP_W = 2;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REGADDR_W-1:0] regaddr_t;
  typedef logic [ALU_OP_W-1:0]  alu_op_t;
  typedef logic [MULT_OP_W-1:0] mult_op_t;

  // ALU opcodes
  localparam alu_op_t ALU_ADD  = 4'h0;
  localparam alu_op_t ALU_SUB  = 4'h1;
  localparam alu_op_t ALU_AND  = 4'h2;
  localparam alu_op_t ALU_OR   = 4'h3;
  localparam alu_op_t ALU_XOR  = 4'h4;
  localparam alu_op_t ALU_SLL  = 4'h5;
  localparam alu_op_t ALU_SRL  = 4'h6;
  localparam alu_op_t ALU_SRA  = 4'h7;
  localparam alu_op_t ALU_SLT  = 4'h8;
  localparam alu_op_t ALU_SLTU = 4'h9;
  // Branch comparisons
  localparam alu_op_t ALU_EQ   = 4'ha;
  localparam alu_op_t ALU_NE   = 4'hb;
  localparam alu_op_t ALU_LT   = 4'hc;
  localparam alu_op_t ALU_GE   = 4'hd;

  // Multiplier opcodes
  localparam mult_op_t MUL_LO    = 2'd0;
  localparam mult_op_t MUL_HI_SS = 2'd1;
  localparam mult_op_t MUL_HI_UU = 2'd2;

  typedef enum logic [0:0] {
    MULT_IDLE,
    MULT_HIGH
  } mult_state_e;

  // Instruction issued from decode
  typedef struct packed {
    logic     alu_en;
    alu_op_t  alu_op;
    word_t    op_a;
    word_t    op_b;
    word_t    op_c;
    logic     mult_en;
    mult_op_t mult_op;
    logic     csr_access;
    logic     lsu_en;
    logic     branch_in_ex;
    logic     alu_we;
    regaddr_t alu_waddr;
    logic     we;
    regaddr_t waddr;
  } ex_req_t;

  // Register file write port
  typedef struct packed {
    logic     we;
    regaddr_t waddr;
    word_t    wdata;
  } wport_t;

endpackage

/* ex_alu.sv */
// Integer ALU with branch compare
`timescale 1ns/1ps

module ex_alu (
  input  ex_stage_pkg::alu_op_t op_i,
  input  ex_stage_pkg::word_t   op_a_i,
  input  ex_stage_pkg::word_t   op_b_i,
  output ex_stage_pkg::word_t   result_o,
  output logic                  cmp_o
);

  logic        sub_op;
  logic        signed_op;
  logic [32:0] add_a;
  logic [32:0] add_b;
  logic [32:0] add_sum;
  logic        lt;
  logic        eq;
  logic [4:0]  shamt;

  ////////////////////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////////////////////

  // Subtract for SUB and every less-than style compare
  assign sub_op = (op_i == ex_stage_pkg::ALU_SUB)  |
                  (op_i == ex_stage_pkg::ALU_SLT)  |
                  (op_i == ex_stage_pkg::ALU_SLTU) |
                  (op_i == ex_stage_pkg::ALU_LT)   |
                  (op_i == ex_stage_pkg::ALU_GE);

  // SLTU is the only unsigned compare
  assign signed_op = (op_i != ex_stage_pkg::ALU_SLTU);

  // 33 bit operands so bit 32 carries the sign of the difference
  assign add_a = {signed_op & op_a_i[31], op_a_i};
  assign add_b = sub_op ? ~{signed_op & op_b_i[31], op_b_i}
                        :  {signed_op & op_b_i[31], op_b_i};

  // Carry in of one completes the two's complement
  assign add_sum = add_a + add_b + {32'b0, sub_op};

  assign lt    = add_sum[32];
  assign eq    = (op_a_i == op_b_i);
  assign shamt = op_b_i[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Compare and result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cmp_o = 1'b0;
    case (op_i)
      ex_stage_pkg::ALU_SLT,
      ex_stage_pkg::ALU_SLTU,
      ex_stage_pkg::ALU_LT:   cmp_o = lt;
      ex_stage_pkg::ALU_GE:   cmp_o = ~lt;
      ex_stage_pkg::ALU_EQ:   cmp_o = eq;
      ex_stage_pkg::ALU_NE:   cmp_o = ~eq;
      default:                cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    // Comparison opcodes fall through to the zero-extended flag
    result_o = {31'b0, cmp_o};
    case (op_i)
      ex_stage_pkg::ALU_ADD,
      ex_stage_pkg::ALU_SUB:  result_o = add_sum[31:0];
      ex_stage_pkg::ALU_AND:  result_o = op_a_i & op_b_i;
      ex_stage_pkg::ALU_OR:   result_o = op_a_i | op_b_i;
      ex_stage_pkg::ALU_XOR:  result_o = op_a_i ^ op_b_i;
      ex_stage_pkg::ALU_SLL:  result_o = op_a_i << shamt;
      ex_stage_pkg::ALU_SRL:  result_o = op_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ex_stage_pkg::ALU_SRA:  result_o = ex_stage_pkg::word_t'($signed(op_a_i) >>> shamt);
      default:                result_o = {31'b0, cmp_o};
    endcase
  end

endmodule

/* ex_mult.sv */
// Integer multiplier
`timescale 1ns/1ps

module ex_mult (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en_i,
  input  ex_stage_pkg::mult_op_t op_i,
  input  ex_stage_pkg::word_t    op_a_i,
  input  ex_stage_pkg::word_t    op_b_i,
  input  logic                   ex_ready_i,
  output ex_stage_pkg::word_t    result_o,
  output logic                   ready_o,
  output logic                   multicycle_o
);

  ex_stage_pkg::mult_state_e state_q;
  ex_stage_pkg::mult_state_e state_d;

  logic                hi_signed;
  logic                hi_op;
  logic                hi_load;
  logic [63:0]         a_ext;
  logic [63:0]         b_ext;
  logic [63:0]         prod;
  ex_stage_pkg::word_t hi_q;

  ////////////////////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////////////////////

  assign hi_signed = (op_i == ex_stage_pkg::MUL_HI_SS);
  assign hi_op     = en_i & (op_i != ex_stage_pkg::MUL_LO);

  // Sign extend only for the signed high word
  assign a_ext = {{32{hi_signed & op_a_i[31]}}, op_a_i};
  assign b_ext = {{32{hi_signed & op_b_i[31]}}, op_b_i};

  // Low 64 bits of the extended product are exact either way
  assign prod = a_ext * b_ext;

  ////////////////////////////////////////////////////////////////////////////
  // High word FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    hi_load      = 1'b0;
    result_o     = prod[31:0];
    case (state_q)
      ex_stage_pkg::MULT_IDLE: begin
        // First cycle of MULH and MULHU stalls the stage
        if (hi_op) begin
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          hi_load      = 1'b1;
          state_d      = ex_stage_pkg::MULT_HIGH;
        end
      end
      ex_stage_pkg::MULT_HIGH: begin
        result_o = hi_q;
        // Stay here under back-pressure
        if (ex_ready_i) begin
          state_d = ex_stage_pkg::MULT_IDLE;
        end
      end
      default: state_d = ex_stage_pkg::MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_stage_pkg::MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Pipeline stage that breaks the wide product path
  always_ff @(posedge clk) begin
    if (hi_load) begin
      hi_q <= prod[63:32];
    end
  end

endmodule

/* ex_writeback.sv */
// Forwarding port and EX/WB load register
`timescale 1ns/1ps

module ex_writeback (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_stage_pkg::ex_req_t req_i,
  input  ex_stage_pkg::word_t   alu_result_i,
  input  ex_stage_pkg::word_t   mult_result_i,
  input  ex_stage_pkg::word_t   csr_rdata_i,
  input  ex_stage_pkg::word_t   lsu_rdata_i,
  input  logic                  lsu_err_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  output ex_stage_pkg::wport_t  fw_port_o,
  output ex_stage_pkg::wport_t  wb_port_o
);

  logic                   load_we;
  logic                   we_q;
  ex_stage_pkg::regaddr_t waddr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port back to decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we    = req_i.alu_we;
    fw_port_o.waddr = req_i.alu_waddr;
    // CSR first, then multiplier, ALU last
    if (req_i.csr_access) begin
      fw_port_o.wdata = csr_rdata_i;
    end else if (req_i.mult_en) begin
      fw_port_o.wdata = mult_result_i;
    end else begin
      fw_port_o.wdata = alu_result_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register for load destinations
  ////////////////////////////////////////////////////////////////////////////

  // Faulting loads never reach the register file
  assign load_we = req_i.we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_i) begin
      we_q <= load_we;
      if (load_we) begin
        waddr_q <= req_i.waddr;
      end
    end else if (wb_ready_i) begin
      // Nothing issued, push a bubble into WB
      we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the WB cycle itself
  assign wb_port_o.we    = we_q;
  assign wb_port_o.waddr = waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

endmodule

/* ex_stage.sv */
// Integer execute stage
`timescale 1ns/1ps

module ex_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_stage_pkg::ex_req_t req_i,
  input  ex_stage_pkg::word_t   csr_rdata_i,
  input  ex_stage_pkg::word_t   lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  wb_ready_i,
  output ex_stage_pkg::wport_t  fw_port_o,
  output ex_stage_pkg::wport_t  wb_port_o,
  output ex_stage_pkg::word_t   jump_target_o,
  output logic                  branch_decision_o,
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  ex_stage_pkg::word_t alu_result;
  ex_stage_pkg::word_t mult_result;
  logic                alu_cmp;
  logic                mult_ready;
  logic                units_ready;
  logic                any_en;

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i     (req_i.alu_op),
    .op_a_i   (req_i.op_a),
    .op_b_i   (req_i.op_b),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (req_i.mult_en),
    .op_i         (req_i.mult_op),
    .op_a_i       (req_i.op_a),
    .op_b_i       (req_i.op_b),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback u_wb (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .lsu_err_i     (lsu_err_i),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = req_i.alu_en | req_i.mult_en | req_i.csr_access | req_i.lsu_en;

  // Branches finish here and never wait on WB
  assign ex_ready_o = units_ready | req_i.branch_in_ex;
  // Valid stays independent of ex_ready
  assign ex_valid_o = any_en & units_ready;

  // Branch target and outcome to fetch
  assign jump_target_o     = req_i.op_c;
  assign branch_decision_o = alu_cmp;

endmodule

/* ex_stage_checker.sv */
// Execute stage output checker
`timescale 1ns/1ps

module ex_stage_checker (
  input  logic                 clk,
  input  logic                 check_i,
  input  logic [63:0]          name_i,
  // Expected values from the testbench
  input  ex_stage_pkg::wport_t exp_fw_i,
  input  logic                 fw_data_en_i,
  input  ex_stage_pkg::wport_t exp_wb_i,
  input  logic                 branch_en_i,
  input  logic                 exp_branch_i,
  input  ex_stage_pkg::word_t  exp_jump_i,
  input  logic                 exp_ready_i,
  input  logic                 exp_valid_i,
  input  logic                 exp_multicycle_i,
  // Observed DUT ports
  input  ex_stage_pkg::wport_t fw_port_i,
  input  ex_stage_pkg::wport_t wb_port_i,
  input  ex_stage_pkg::word_t  jump_target_i,
  input  logic                 branch_decision_i,
  input  logic                 mult_multicycle_i,
  input  logic                 ex_ready_i,
  input  logic                 ex_valid_i,
  output int                   err_cnt_o,
  output int                   chk_cnt_o
);

  int err_cnt = 0;
  int chk_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  // One field against its expected value
  task automatic compare(
    input string       field,
    input logic [31:0] exp_v,
    input logic [31:0] act_v
  );
    chk_cnt = chk_cnt + 1;
    if (act_v !== exp_v) begin
      err_cnt = err_cnt + 1;
      $display("mismatch %s %s: expected %h actual %h", name_i, field, exp_v, act_v);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sample on the falling edge, inputs settled since 1 ns after rise
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (check_i) begin
      // Forwarding port
      compare("fw_we", 32'(exp_fw_i.we), 32'(fw_port_i.we));
      compare("fw_waddr", 32'(exp_fw_i.waddr), 32'(fw_port_i.waddr));
      if (fw_data_en_i) begin
        compare("fw_wdata", exp_fw_i.wdata, fw_port_i.wdata);
      end
      // Handshake and multiplier stall
      compare("ex_ready", 32'(exp_ready_i), 32'(ex_ready_i));
      compare("ex_valid", 32'(exp_valid_i), 32'(ex_valid_i));
      compare("multicycle", 32'(exp_multicycle_i), 32'(mult_multicycle_i));
      if (branch_en_i) begin
        compare("branch", 32'(exp_branch_i), 32'(branch_decision_i));
        compare("jump_target", exp_jump_i, jump_target_i);
      end
      // Load writeback, address and data only matter with we set
      compare("wb_we", 32'(exp_wb_i.we), 32'(wb_port_i.we));
      if (exp_wb_i.we) begin
        compare("wb_waddr", 32'(exp_wb_i.waddr), 32'(wb_port_i.waddr));
        compare("wb_wdata", exp_wb_i.wdata, wb_port_i.wdata);
      end
    end
  end

endmodule

/* tb_ex_stage.sv */
// Execute stage testbench
`timescale 1ns/1ps

module tb_ex_stage;

  typedef enum logic [2:0] {
    K_ALU,
    K_BR,
    K_MUL,
    K_CSR,
    K_LOAD,
    K_IDLE
  } kind_e;

  // One table row of stimulus plus expected results
  typedef struct packed {
    logic [63:0]            name;
    kind_e                  kind;
    ex_stage_pkg::alu_op_t  op;
    ex_stage_pkg::word_t    a;
    ex_stage_pkg::word_t    b;
    ex_stage_pkg::word_t    c;
    ex_stage_pkg::regaddr_t rd;
    logic                   wb_ready;
    logic                   lsu_ready;
    logic                   lsu_err;
    ex_stage_pkg::word_t    exp_data;
    logic                   exp_cmp;
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  ex_stage_pkg::ex_req_t  req;
  ex_stage_pkg::word_t    csr_rdata;
  ex_stage_pkg::word_t    lsu_rdata;
  logic                   lsu_ready_ex;
  logic                   lsu_err;
  logic                   wb_ready;
  ex_stage_pkg::wport_t   fw_port;
  ex_stage_pkg::wport_t   wb_port;
  ex_stage_pkg::word_t    jump_target;
  logic                   branch_decision;
  logic                   mult_multicycle;
  logic                   ex_ready;
  logic                   ex_valid;

  // Expected values handed to the checker
  logic                   check_en;
  logic [63:0]            cur_name;
  ex_stage_pkg::wport_t   exp_fw;
  ex_stage_pkg::wport_t   exp_wb;
  logic                   fw_data_en;
  logic                   branch_en;
  logic                   exp_branch;
  ex_stage_pkg::word_t    exp_jump;
  logic                   exp_ready;
  logic                   exp_valid;
  logic                   exp_mc;

  // EX/WB register model
  logic                   model_we;
  ex_stage_pkg::regaddr_t model_waddr;

  int                     err_cnt;
  int                     chk_cnt;
  int                     cycle_cnt;
  int                     cycle_limit;
  logic [31:0]            lfsr_q;
  entry_t                 tbl[$];

  ex_stage dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .wb_ready_i        (wb_ready),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  ex_stage_checker chk (
    .clk               (clk),
    .check_i           (check_en),
    .name_i            (cur_name),
    .exp_fw_i          (exp_fw),
    .fw_data_en_i      (fw_data_en),
    .exp_wb_i          (exp_wb),
    .branch_en_i       (branch_en),
    .exp_branch_i      (exp_branch),
    .exp_jump_i        (exp_jump),
    .exp_ready_i       (exp_ready),
    .exp_valid_i       (exp_valid),
    .exp_multicycle_i  (exp_mc),
    .fw_port_i         (fw_port),
    .wb_port_i         (wb_port),
    .jump_target_i     (jump_target),
    .branch_decision_i (branch_decision),
    .mult_multicycle_i (mult_multicycle),
    .ex_ready_i        (ex_ready),
    .ex_valid_i        (ex_valid),
    .err_cnt_o         (err_cnt),
    .chk_cnt_o         (chk_cnt)
  );

  // 40 ns period
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random operands and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32 22 2 1 with one step per bit taken
  function automatic ex_stage_pkg::word_t rand_word();
    ex_stage_pkg::word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      w      = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic logic [7:0] hex_char(input logic [3:0] v);
    return (v < 4'd10) ? (8'h30 + {4'h0, v}) : (8'h57 + {4'h0, v});
  endfunction

  function automatic logic ref_cmp(
    input ex_stage_pkg::alu_op_t op,
    input ex_stage_pkg::word_t   a,
    input ex_stage_pkg::word_t   b
  );
    case (op)
      ex_stage_pkg::ALU_SLT,
      ex_stage_pkg::ALU_LT:   return $signed(a) < $signed(b);
      ex_stage_pkg::ALU_SLTU: return a < b;
      ex_stage_pkg::ALU_GE:   return $signed(a) >= $signed(b);
      ex_stage_pkg::ALU_EQ:   return a == b;
      ex_stage_pkg::ALU_NE:   return a != b;
      default:                return 1'b0;
    endcase
  endfunction

  function automatic ex_stage_pkg::word_t ref_alu(
    input ex_stage_pkg::alu_op_t op,
    input ex_stage_pkg::word_t   a,
    input ex_stage_pkg::word_t   b
  );
    case (op)
      ex_stage_pkg::ALU_ADD: return a + b;
      ex_stage_pkg::ALU_SUB: return a - b;
      ex_stage_pkg::ALU_AND: return a & b;
      ex_stage_pkg::ALU_OR:  return a | b;
      ex_stage_pkg::ALU_XOR: return a ^ b;
      ex_stage_pkg::ALU_SLL: return a << b[4:0];
      ex_stage_pkg::ALU_SRL: return a >> b[4:0];
      ex_stage_pkg::ALU_SRA: return $signed(a) >>> b[4:0];
      default:               return {31'b0, ref_cmp(op, a, b)};
    endcase
  endfunction

  function automatic ex_stage_pkg::word_t ref_mul(
    input ex_stage_pkg::mult_op_t op,
    input ex_stage_pkg::word_t    a,
    input ex_stage_pkg::word_t    b
  );
    logic signed [63:0] ps;
    logic [63:0]        pu;
    ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    pu = {32'b0, a} * {32'b0, b};
    case (op)
      ex_stage_pkg::MUL_HI_SS: return ps[63:32];
      ex_stage_pkg::MUL_HI_UU: return pu[63:32];
      default:                 return pu[31:0];
    endcase
  endfunction

  function automatic logic is_high_mul(input entry_t e);
    return (e.kind == K_MUL) && (e.op[1:0] != ex_stage_pkg::MUL_LO);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(
    input logic [63:0]            name,
    input kind_e                  kind,
    input ex_stage_pkg::alu_op_t  op,
    input ex_stage_pkg::word_t    a,
    input ex_stage_pkg::word_t    b,
    input ex_stage_pkg::word_t    c,
    input ex_stage_pkg::regaddr_t rd,
    input logic                   wb_rdy,
    input logic                   err
  );
    entry_t e;
    e.name      = name;
    e.kind      = kind;
    e.op        = op;
    e.a         = a;
    e.b         = b;
    e.c         = c;
    e.rd        = rd;
    e.wb_ready  = wb_rdy;
    e.lsu_ready = 1'b1;
    e.lsu_err   = err;
    e.exp_cmp   = ref_cmp(op, a, b);
    case (kind)
      K_MUL:   e.exp_data = ref_mul(op[1:0], a, b);
      // CSR read data rides on op_c
      K_CSR:   e.exp_data = c;
      default: e.exp_data = ref_alu(op, a, b);
    endcase
    tbl.push_back(e);
  endtask

  task automatic build_table();
    entry_t              e;
    ex_stage_pkg::word_t ra;
    ex_stage_pkg::word_t rb;
    ex_stage_pkg::word_t rc;
    // Every ALU opcode on fixed then random operands
    for (int i = 0; i < 14; i++) begin
      add_row({"alu_fx_", hex_char(4'(i))}, K_ALU, 4'(i), 32'hffff_fff0, 32'h0000_0013,
              32'h0, 6'(i + 1), 1'b1, 1'b0);
    end
    for (int i = 0; i < 14; i++) begin
      ra = rand_word();
      rb = rand_word();
      add_row({"alu_rn_", hex_char(4'(i))}, K_ALU, 4'(i), ra, rb, 32'h0, 6'(i + 33),
              1'b1, 1'b0);
    end
    // Branches with WB stalled on some
    add_row("br_eq_01", K_BR, ex_stage_pkg::ALU_EQ, 32'd5, 32'd5, 32'h0000_4000, 6'd0, 1'b0, 1'b0);
    add_row("br_ne_02", K_BR, ex_stage_pkg::ALU_NE, 32'd5, 32'd5, 32'h0000_4010, 6'd0, 1'b1, 1'b0);
    add_row("br_lt_03", K_BR, ex_stage_pkg::ALU_LT, 32'hffff_fff0, 32'h10, 32'h0000_8024,
            6'd0, 1'b0, 1'b0);
    add_row("br_ge_04", K_BR, ex_stage_pkg::ALU_GE, 32'hffff_fff0, 32'h10, 32'h0001_0000,
            6'd0, 1'b1, 1'b0);
    ra = rand_word();
    rb = rand_word();
    rc = rand_word();
    add_row("br_ge_rn", K_BR, ex_stage_pkg::ALU_GE, ra, rb, rc, 6'd0, 1'b0, 1'b0);
    // Multiplier rows with no two high-word rows back to back
    add_row("mul_lo_f", K_MUL, {2'b0, ex_stage_pkg::MUL_LO}, 32'hffff_fffe, 32'd3, 32'h0,
            6'd40, 1'b1, 1'b0);
    add_row("mul_ss_f", K_MUL, {2'b0, ex_stage_pkg::MUL_HI_SS}, 32'hffff_fffe, 32'd3, 32'h0,
            6'd41, 1'b1, 1'b0);
    ra = rand_word();
    rb = rand_word();
    add_row("mul_lo_r", K_MUL, {2'b0, ex_stage_pkg::MUL_LO}, ra, rb, 32'h0, 6'd42, 1'b1, 1'b0);
    add_row("mul_uu_f", K_MUL, {2'b0, ex_stage_pkg::MUL_HI_UU}, 32'hffff_fffe, 32'd3, 32'h0,
            6'd43, 1'b1, 1'b0);
    ra = rand_word();
    rb = rand_word();
    rc = rand_word();
    add_row("csr_sub1", K_CSR, ex_stage_pkg::ALU_SUB, ra, rb, rc, 6'd44, 1'b1, 1'b0);
    ra = rand_word();
    rb = rand_word();
    add_row("mul_ss_r", K_MUL, {2'b0, ex_stage_pkg::MUL_HI_SS}, ra, rb, 32'h0, 6'd45, 1'b1, 1'b0);
    ra = rand_word();
    rb = rand_word();
    rc = rand_word();
    add_row("csr_add2", K_CSR, ex_stage_pkg::ALU_ADD, ra, rb, rc, 6'd46, 1'b1, 1'b0);
    ra = rand_word();
    rb = rand_word();
    add_row("mul_uu_r", K_MUL, {2'b0, ex_stage_pkg::MUL_HI_UU}, ra, rb, 32'h0, 6'd47, 1'b1, 1'b0);
    // Loads with error, stall hold and bubble clear
    for (int i = 0; i < 6; i++) begin
      ra = rand_word();
      rb = rand_word();
      case (i)
        0: add_row("ld_ok_05", K_LOAD, 4'h0, ra, rb, 32'h0, 6'd5, 1'b1, 1'b0);
        1: add_row("ld_err09", K_LOAD, 4'h0, ra, rb, 32'h0, 6'd9, 1'b1, 1'b1);
        2: add_row("ld_ok_12", K_LOAD, 4'h0, ra, rb, 32'h0, 6'd12, 1'b1, 1'b0);
        3: add_row("ld_stall", K_LOAD, 4'h0, ra, rb, 32'h0, 6'd20, 1'b0, 1'b0);
        4: add_row("idle_hld", K_IDLE, 4'h0, ra, rb, 32'h0, 6'd0, 1'b1, 1'b0);
        default: add_row("idle_clr", K_IDLE, 4'h0, ra, rb, 32'h0, 6'd0, 1'b1, 1'b0);
      endcase
    end
    // Load held off by the LSU
    ra = rand_word();
    rb = rand_word();
    add_row("ld_lsuwt", K_LOAD, 4'h0, ra, rb, 32'h0, 6'd21, 1'b1, 1'b0);
    e = tbl.pop_back();
    e.lsu_ready = 1'b0;
    tbl.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and expect
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_req(input entry_t e);
    req      = '0;
    req.op_a = e.a;
    req.op_b = e.b;
    req.op_c = e.c;
    case (e.kind)
      K_ALU: begin
        req.alu_en    = 1'b1;
        req.alu_op    = e.op;
        req.alu_we    = 1'b1;
        req.alu_waddr = e.rd;
      end
      K_BR: begin
        req.alu_op       = e.op;
        req.branch_in_ex = 1'b1;
      end
      K_MUL: begin
        req.mult_en   = 1'b1;
        req.mult_op   = e.op[1:0];
        req.alu_we    = 1'b1;
        req.alu_waddr = e.rd;
      end
      K_CSR: begin
        req.csr_access = 1'b1;
        req.alu_en     = 1'b1;
        req.alu_op     = e.op;
        req.alu_we     = 1'b1;
        req.alu_waddr  = e.rd;
      end
      K_LOAD: begin
        req.lsu_en = 1'b1;
        req.we     = 1'b1;
        req.waddr  = e.rd;
      end
      default: begin
      end
    endcase
    csr_rdata    = e.c;
    lsu_rdata    = e.a ^ e.b;
    wb_ready     = e.wb_ready;
    lsu_ready_ex = e.lsu_ready;
    lsu_err      = e.lsu_err;
  endtask

  task automatic set_expect(input entry_t e, input int cyc);
    logic first;
    logic any_en;
    // First cycle of a high-word multiply stalls
    first  = is_high_mul(e) && (cyc == 0);
    any_en = req.alu_en | req.mult_en | req.csr_access | req.lsu_en;
    cur_name     = e.name;
    exp_mc       = first;
    exp_ready    = (~first & lsu_ready_ex & wb_ready) | req.branch_in_ex;
    exp_valid    = any_en & ~first & lsu_ready_ex & wb_ready;
    exp_fw.we    = req.alu_we;
    exp_fw.waddr = req.alu_waddr;
    exp_fw.wdata = e.exp_data;
    fw_data_en   = (e.kind == K_ALU || e.kind == K_MUL || e.kind == K_CSR) && !first;
    branch_en    = (e.kind == K_BR);
    exp_branch   = e.exp_cmp;
    exp_jump     = e.c;
    exp_wb.we    = model_we;
    exp_wb.waddr = model_waddr;
    exp_wb.wdata = lsu_rdata;
  endtask

  // Clock edge rule of the EX/WB register
  task automatic update_wb_model();
    if (exp_valid) begin
      model_we = req.we & ~lsu_err;
      if (req.we & ~lsu_err) begin
        model_waddr = req.waddr;
      end
    end else if (wb_ready) begin
      model_we = 1'b0;
    end
  endtask

  initial begin
    entry_t e;
    int     ncyc;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = '0;
    csr_rdata    = '0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    wb_ready     = 1'b1;
    check_en     = 1'b0;
    cycle_cnt    = 0;
    model_we     = 1'b0;
    model_waddr  = '0;
    lfsr_q       = 32'h2950_4936;
    build_table();
    cycle_limit = 10 + 4 * tbl.size() + 20;

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < tbl.size(); i++) begin
      e = tbl[i];
      if (is_high_mul(e)) begin
        while (!ex_ready) begin
          @(posedge clk);
          #1;
        end
      end
      drive_req(e);
      ncyc = is_high_mul(e) ? 2 : 1;
      for (int c = 0; c < ncyc; c++) begin
        set_expect(e, c);
        check_en = 1'b1;
        @(posedge clk);
        update_wb_model();
        #1;
      end
    end
    check_en = 1'b0;

    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* ex_stage.f */
ex_stage_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
ex_stage_checker.sv
tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f ex_stage.f \
  --top-module tb_ex_stage -o sim_ex_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_ex_stage)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1
